/* Bender.yml */
package:
  name: exec_stage

sources:
  - source/exec_pkg.sv
  - source/exec_uop_if.sv
  - source/alu.sv
  - source/branch_resolve.sv
  - source/execute_stage.sv
  - source/execute_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/exec_tb_top.sv

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
    input  exec_pkg::alu_op_e op_i,
    input  exec_pkg::xlen_t   a_i,
    input  exec_pkg::xlen_t   b_i,
    output exec_pkg::xlen_t   result_o,
    output logic              eq_o,
    output logic              lt_o
);
    import exec_pkg::*;

    logic [4:0] shamt;
    logic       lt_unsigned;

    assign shamt       = b_i[4:0];
    assign lt_unsigned = (a_i < b_i);

    // Flags are valid for any op so that branches see them directly.
    assign eq_o = (a_i == b_i);
    assign lt_o = ($signed(a_i) < $signed(b_i));

    always_comb begin
        case (op_i)
            ALU_ADD: begin
                result_o = a_i + b_i;
            end
            ALU_SUB: begin
                result_o = a_i - b_i;
            end
            ALU_AND: begin
                result_o = a_i & b_i;
            end
            ALU_OR: begin
                result_o = a_i | b_i;
            end
            ALU_XOR: begin
                result_o = a_i ^ b_i;
            end
            ALU_SLL: begin
                result_o = a_i << shamt;
            end
            ALU_SRL: begin
                result_o = a_i >> shamt;
            end
            ALU_SRA: begin
                result_o = xlen_t'($signed(a_i) >>> shamt);
            end
            ALU_SLT: begin
                result_o = {{(XLEN-1){1'b0}}, lt_o};
            end
            ALU_SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

/* source/branch_resolve.sv */
`timescale 1ns/1ps

module branch_resolve (
    input  exec_pkg::br_op_e br_op_i,
    input  exec_pkg::pc_t    pc_i,
    input  exec_pkg::xlen_t  imm_i,
    input  exec_pkg::xlen_t  rs1_i,
    input  logic             pred_taken_i,
    input  logic             eq_i,
    input  logic             lt_i,
    input  logic             fire_i,
    output logic             redirect_valid_o,
    output exec_pkg::pc_t    redirect_pc_o,
    output logic             bp_update_o,
    output exec_pkg::pc_t    bp_pc_o,
    output logic             bp_taken_o,
    output logic             bp_mispredict_o
);
    import exec_pkg::*;

    logic is_br;
    logic taken;
    logic mispredict;
    pc_t  target;

    always_comb begin
        is_br = 1'b1;
        case (br_op_i)
            BR_BEQ: begin
                taken = eq_i;
            end
            BR_BNE: begin
                taken = !eq_i;
            end
            BR_BLT: begin
                taken = lt_i;
            end
            BR_BGE: begin
                taken = !lt_i;
            end
            BR_JAL, BR_JALR: begin
                taken = 1'b1;
            end
            default: begin
                is_br = 1'b0;
                taken = 1'b0;
            end
        endcase
    end

    // JALR jumps relative to rs1 and never lands on an odd address.
    always_comb begin
        if (br_op_i == BR_JALR) begin
            target = (rs1_i + imm_i) & ~pc_t'(1);
        end else if (taken) begin
            target = pc_i + imm_i;
        end else begin
            target = pc_i + PC_STEP;
        end
    end

    assign mispredict = is_br && (taken != pred_taken_i);

    assign redirect_valid_o = fire_i && mispredict;
    assign redirect_pc_o    = target;
    assign bp_update_o      = fire_i && is_br;
    assign bp_pc_o          = pc_i;
    assign bp_taken_o       = taken;
    assign bp_mispredict_o  = mispredict;

endmodule

/* source/exec_pkg.sv */
package exec_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths fixed by RV32.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int XLEN  = 32;
    localparam int TAG_W = 5;
    localparam int EXC_W = 4;

    typedef logic [XLEN-1:0]  xlen_t;
    typedef logic [XLEN-1:0]  pc_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [EXC_W-1:0] exc_code_t;

    // Distance to the next sequential instruction.
    localparam pc_t PC_STEP = 32'd4;

    // Cause code reported when an MRET leaves the pipeline.
    localparam exc_code_t EXC_MRET = 4'd11;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Micro-op selector fields.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        OP_ZERO = 3'd0,
        OP_RS1  = 3'd1,
        OP_RS2  = 3'd2,
        OP_IMM  = 3'd3,
        OP_CSR  = 3'd4,
        OP_PC   = 3'd5
    } opsel_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_BEQ  = 3'd1,
        BR_BNE  = 3'd2,
        BR_BLT  = 3'd3,
        BR_BGE  = 3'd4,
        BR_JAL  = 3'd5,
        BR_JALR = 3'd6
    } br_op_e;

    typedef enum logic [1:0] {
        CSR_NONE = 2'd0,
        CSR_RW   = 2'd1,
        CSR_RS   = 2'd2,
        CSR_MRET = 2'd3
    } csr_op_e;

    // LINK writes pc plus 4, CSR writes the old CSR value.
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_OP1  = 2'd1,
        WB_LINK = 2'd2,
        WB_CSR  = 2'd3
    } wb_sel_e;

endpackage

/* source/exec_uop_if.sv */
`timescale 1ns/1ps

interface exec_uop_if;
    import exec_pkg::*;

    logic    valid;
    logic    ready;

    pc_t     pc;
    logic    pred_taken;
    tag_t    tag;

    xlen_t   rs1_val;
    xlen_t   rs2_val;
    xlen_t   imm;
    xlen_t   csr_val;

    opsel_e  op1_sel;
    opsel_e  op2_sel;
    alu_op_e alu_op;
    br_op_e  br_op;
    csr_op_e csr_op;
    wb_sel_e wb_sel;

    // The issuing side presents the micro-op, the execute stage answers with ready.
    modport issue (
        output valid, pc, pred_taken, tag, rs1_val, rs2_val, imm, csr_val,
        output op1_sel, op2_sel, alu_op, br_op, csr_op, wb_sel,
        input  ready
    );

    modport stage (
        input  valid, pc, pred_taken, tag, rs1_val, rs2_val, imm, csr_val,
        input  op1_sel, op2_sel, alu_op, br_op, csr_op, wb_sel,
        output ready
    );

endinterface

/* source/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 flush_i,
    exec_uop_if.stage            uop,
    output logic                 out_valid_o,
    input  logic                 out_ready_i,
    output exec_pkg::tag_t       out_tag_o,
    output exec_pkg::pc_t        out_pc_o,
    output exec_pkg::xlen_t      out_rd_val_o,
    output exec_pkg::xlen_t      out_csr_val_o,
    output logic                 redirect_valid_o,
    output exec_pkg::pc_t        redirect_pc_o,
    output logic                 bp_update_o,
    output exec_pkg::pc_t        bp_pc_o,
    output logic                 bp_taken_o,
    output logic                 bp_mispredict_o,
    output logic                 trap_valid_o,
    output exec_pkg::pc_t        trap_pc_o,
    output exec_pkg::exc_code_t  trap_cause_o
);
    import exec_pkg::*;

    function automatic xlen_t sel_operand(input opsel_e sel, input xlen_t rs1,
                                          input xlen_t rs2, input xlen_t imm,
                                          input xlen_t csr, input pc_t pc);
        xlen_t val;
        case (sel)
            OP_RS1:  val = rs1;
            OP_RS2:  val = rs2;
            OP_IMM:  val = imm;
            OP_CSR:  val = csr;
            OP_PC:   val = pc;
            default: val = '0;
        endcase
        return val;
    endfunction

    logic    fire;
    logic    is_cond_br;
    xlen_t   op1;
    xlen_t   op2;
    xlen_t   alu_a;
    xlen_t   alu_b;
    alu_op_e alu_op;
    xlen_t   alu_result;
    logic    alu_eq;
    logic    alu_lt;
    xlen_t   rd_val;
    xlen_t   csr_new;

    logic    out_valid_q;
    tag_t    tag_q;
    pc_t     pc_q;
    xlen_t   rd_q;
    xlen_t   csr_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operands and ALU.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign op1 = sel_operand(uop.op1_sel, uop.rs1_val, uop.rs2_val, uop.imm,
                             uop.csr_val, uop.pc);
    assign op2 = sel_operand(uop.op2_sel, uop.rs1_val, uop.rs2_val, uop.imm,
                             uop.csr_val, uop.pc);

    // Conditional branches compare the two source registers regardless of the selectors.
    assign is_cond_br = (uop.br_op == BR_BEQ) || (uop.br_op == BR_BNE) ||
                        (uop.br_op == BR_BLT) || (uop.br_op == BR_BGE);

    assign alu_a  = is_cond_br ? uop.rs1_val : op1;
    assign alu_b  = is_cond_br ? uop.rs2_val : op2;
    assign alu_op = is_cond_br ? ALU_SUB : uop.alu_op;

    alu u_alu (
        .op_i     (alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .result_o (alu_result),
        .eq_o     (alu_eq),
        .lt_o     (alu_lt)
    );

    branch_resolve u_branch_resolve (
        .br_op_i          (uop.br_op),
        .pc_i             (uop.pc),
        .imm_i            (uop.imm),
        .rs1_i            (uop.rs1_val),
        .pred_taken_i     (uop.pred_taken),
        .eq_i             (alu_eq),
        .lt_i             (alu_lt),
        .fire_i           (fire),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o),
        .bp_update_o      (bp_update_o),
        .bp_pc_o          (bp_pc_o),
        .bp_taken_o       (bp_taken_o),
        .bp_mispredict_o  (bp_mispredict_o)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write-back, CSR and trap.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (uop.wb_sel)
            WB_OP1:  rd_val = op1;
            WB_LINK: rd_val = uop.pc + PC_STEP;
            WB_CSR:  rd_val = uop.csr_val;
            default: rd_val = alu_result;
        endcase
    end

    // For RS the ALU is expected to OR the old value with the mask.
    always_comb begin
        case (uop.csr_op)
            CSR_RW:  csr_new = uop.rs1_val;
            CSR_RS:  csr_new = alu_result;
            default: csr_new = '0;
        endcase
    end

    assign trap_valid_o = fire && (uop.csr_op == CSR_MRET);
    assign trap_pc_o    = uop.pc;
    assign trap_cause_o = EXC_MRET;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output register toward memory.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign uop.ready = !out_valid_q || out_ready_i;
    assign fire      = uop.valid && uop.ready && !flush_i;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            out_valid_q <= 1'b0;
        end else if (flush_i) begin
            out_valid_q <= 1'b0;
        end else if (fire) begin
            out_valid_q <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fire) begin
            tag_q <= uop.tag;
            pc_q  <= uop.pc;
            rd_q  <= rd_val;
            csr_q <= csr_new;
        end
    end

    assign out_valid_o   = out_valid_q;
    assign out_tag_o     = tag_q;
    assign out_pc_o      = pc_q;
    assign out_rd_val_o  = rd_q;
    assign out_csr_val_o = csr_q;

endmodule

/* source/execute_top.sv */
`timescale 1ns/1ps

module execute_top (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 flush_i,
    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    input  exec_pkg::pc_t        pc_i,
    input  logic                 pred_taken_i,
    input  exec_pkg::tag_t       tag_i,
    input  exec_pkg::xlen_t      rs1_val_i,
    input  exec_pkg::xlen_t      rs2_val_i,
    input  exec_pkg::xlen_t      imm_i,
    input  exec_pkg::xlen_t      csr_val_i,
    input  exec_pkg::opsel_e     op1_sel_i,
    input  exec_pkg::opsel_e     op2_sel_i,
    input  exec_pkg::alu_op_e    alu_op_i,
    input  exec_pkg::br_op_e     br_op_i,
    input  exec_pkg::csr_op_e    csr_op_i,
    input  exec_pkg::wb_sel_e    wb_sel_i,
    output logic                 out_valid_o,
    input  logic                 out_ready_i,
    output exec_pkg::tag_t       out_tag_o,
    output exec_pkg::pc_t        out_pc_o,
    output exec_pkg::xlen_t      out_rd_val_o,
    output exec_pkg::xlen_t      out_csr_val_o,
    output logic                 redirect_valid_o,
    output exec_pkg::pc_t        redirect_pc_o,
    output logic                 bp_update_o,
    output exec_pkg::pc_t        bp_pc_o,
    output logic                 bp_taken_o,
    output logic                 bp_mispredict_o,
    output logic                 trap_valid_o,
    output exec_pkg::pc_t        trap_pc_o,
    output exec_pkg::exc_code_t  trap_cause_o
);

    exec_uop_if uop_bus ();

    // Issue side of the bus is driven straight from the top-level ports.
    assign uop_bus.valid      = in_valid_i;
    assign uop_bus.pc         = pc_i;
    assign uop_bus.pred_taken = pred_taken_i;
    assign uop_bus.tag        = tag_i;
    assign uop_bus.rs1_val    = rs1_val_i;
    assign uop_bus.rs2_val    = rs2_val_i;
    assign uop_bus.imm        = imm_i;
    assign uop_bus.csr_val    = csr_val_i;
    assign uop_bus.op1_sel    = op1_sel_i;
    assign uop_bus.op2_sel    = op2_sel_i;
    assign uop_bus.alu_op     = alu_op_i;
    assign uop_bus.br_op      = br_op_i;
    assign uop_bus.csr_op     = csr_op_i;
    assign uop_bus.wb_sel     = wb_sel_i;
    assign in_ready_o         = uop_bus.ready;

    execute_stage u_execute_stage (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .flush_i          (flush_i),
        .uop              (uop_bus.stage),
        .out_valid_o      (out_valid_o),
        .out_ready_i      (out_ready_i),
        .out_tag_o        (out_tag_o),
        .out_pc_o         (out_pc_o),
        .out_rd_val_o     (out_rd_val_o),
        .out_csr_val_o    (out_csr_val_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o),
        .bp_update_o      (bp_update_o),
        .bp_pc_o          (bp_pc_o),
        .bp_taken_o       (bp_taken_o),
        .bp_mispredict_o  (bp_mispredict_o),
        .trap_valid_o     (trap_valid_o),
        .trap_pc_o        (trap_pc_o),
        .trap_cause_o     (trap_cause_o)
    );

endmodule

/* sources.f */
+incdir+verification
source/exec_pkg.sv
source/exec_uop_if.sv
source/alu.sv
source/branch_resolve.sv
source/execute_stage.sv
source/execute_top.sv
verification/exec_tb_top.sv

/* verification/exec_ref_model.svh */
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

// One micro-op as presented at the input ports.
typedef struct packed {
    pc_t     pc;
    logic    pred_taken;
    tag_t    tag;
    xlen_t   rs1;
    xlen_t   rs2;
    xlen_t   imm;
    xlen_t   csr;
    opsel_e  op1_sel;
    opsel_e  op2_sel;
    alu_op_e alu_op;
    br_op_e  br_op;
    csr_op_e csr_op;
    wb_sel_e wb_sel;
} uop_t;

// Everything the stage should produce for that micro-op.
typedef struct {
    tag_t  tag;
    pc_t   pc;
    xlen_t rd;
    xlen_t csr;
    logic  is_br;
    logic  taken;
    logic  mispredict;
    pc_t   target;
    logic  trap;
} exp_t;

function automatic xlen_t pick_operand(input uop_t u, input opsel_e sel);
    xlen_t v;
    case (sel)
        OP_RS1:  v = u.rs1;
        OP_RS2:  v = u.rs2;
        OP_IMM:  v = u.imm;
        OP_CSR:  v = u.csr;
        OP_PC:   v = u.pc;
        default: v = 32'd0;
    endcase
    return v;
endfunction

function automatic xlen_t alu_model(input alu_op_e op, input xlen_t a, input xlen_t b);
    xlen_t r;
    case (op)
        ALU_ADD:  r = a + b;
        ALU_SUB:  r = a - b;
        ALU_AND:  r = a & b;
        ALU_OR:   r = a | b;
        ALU_XOR:  r = a ^ b;
        ALU_SLL:  r = a << b[4:0];
        ALU_SRL:  r = a >> b[4:0];
        ALU_SRA:  r = xlen_t'($signed(a) >>> b[4:0]);
        ALU_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
        default:  r = 32'd0;
    endcase
    return r;
endfunction

function automatic exp_t model_uop(input uop_t u);
    exp_t  e;
    xlen_t op1;
    xlen_t op2;
    xlen_t res;
    logic  cond_br;
    op1 = pick_operand(u, u.op1_sel);
    op2 = pick_operand(u, u.op2_sel);
    // Conditional branches run rs1 minus rs2 through the ALU.
    cond_br = u.br_op inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE};
    res = cond_br ? alu_model(ALU_SUB, u.rs1, u.rs2) : alu_model(u.alu_op, op1, op2);
    e.tag = u.tag;
    e.pc = u.pc;
    case (u.wb_sel)
        WB_ALU:  e.rd = res;
        WB_OP1:  e.rd = op1;
        WB_LINK: e.rd = u.pc + 32'd4;
        default: e.rd = u.csr;
    endcase
    case (u.csr_op)
        CSR_RW:  e.csr = u.rs1;
        CSR_RS:  e.csr = res;
        default: e.csr = 32'd0;
    endcase
    case (u.br_op)
        BR_BEQ:  e.taken = (u.rs1 == u.rs2);
        BR_BNE:  e.taken = (u.rs1 != u.rs2);
        BR_BLT:  e.taken = ($signed(u.rs1) < $signed(u.rs2));
        BR_BGE:  e.taken = ($signed(u.rs1) >= $signed(u.rs2));
        BR_JAL:  e.taken = 1'b1;
        BR_JALR: e.taken = 1'b1;
        default: e.taken = 1'b0;
    endcase
    e.is_br = (u.br_op != BR_NONE);
    if (u.br_op == BR_JALR) begin
        e.target = (u.rs1 + u.imm) & 32'hffff_fffe;
    end else begin
        e.target = e.taken ? u.pc + u.imm : u.pc + 32'd4;
    end
    e.mispredict = e.is_br && (e.taken != u.pred_taken);
    e.trap = (u.csr_op == CSR_MRET);
    return e;
endfunction

`endif

/* verification/exec_tb_top.sv */
`timescale 1ns/1ps

module exec_tb_top;
    import exec_pkg::*;

    `include "exec_ref_model.svh"

    localparam int unsigned SEED = 32'h4fa89cea;

    logic      clk_i;
    logic      rstn_i;
    logic      flush_i;
    logic      in_valid_i;
    logic      out_ready_i;
    uop_t      cur;

    logic      in_ready_o;
    logic      out_valid_o;
    tag_t      out_tag_o;
    pc_t       out_pc_o;
    xlen_t     out_rd_val_o;
    xlen_t     out_csr_val_o;
    logic      redirect_valid_o;
    pc_t       redirect_pc_o;
    logic      bp_update_o;
    pc_t       bp_pc_o;
    logic      bp_taken_o;
    logic      bp_mispredict_o;
    logic      trap_valid_o;
    pc_t       trap_pc_o;
    exc_code_t trap_cause_o;

    exp_t      exp_q[$];
    string     test_name;
    int        err_count;
    int        check_count;
    int        tests_failed;
    logic      timed_out;
    logic      last_fire;

    execute_top uut (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .flush_i          (flush_i),
        .in_valid_i       (in_valid_i),
        .in_ready_o       (in_ready_o),
        .pc_i             (cur.pc),
        .pred_taken_i     (cur.pred_taken),
        .tag_i            (cur.tag),
        .rs1_val_i        (cur.rs1),
        .rs2_val_i        (cur.rs2),
        .imm_i            (cur.imm),
        .csr_val_i        (cur.csr),
        .op1_sel_i        (cur.op1_sel),
        .op2_sel_i        (cur.op2_sel),
        .alu_op_i         (cur.alu_op),
        .br_op_i          (cur.br_op),
        .csr_op_i         (cur.csr_op),
        .wb_sel_i         (cur.wb_sel),
        .out_valid_o      (out_valid_o),
        .out_ready_i      (out_ready_i),
        .out_tag_o        (out_tag_o),
        .out_pc_o         (out_pc_o),
        .out_rd_val_o     (out_rd_val_o),
        .out_csr_val_o    (out_csr_val_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o),
        .bp_update_o      (bp_update_o),
        .bp_pc_o          (bp_pc_o),
        .bp_taken_o       (bp_taken_o),
        .bp_mispredict_o  (bp_mispredict_o),
        .trap_valid_o     (trap_valid_o),
        .trap_pc_o        (trap_pc_o),
        .trap_cause_o     (trap_cause_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus and checking helpers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic chance(input int pct);
        return ($urandom_range(99, 0) < pct);
    endfunction

    function automatic uop_t gen_uop(input int mode);
        uop_t u;
        int   m;
        m = mode;
        // Back-pressure and flush tests mix all micro-op kinds.
        if (mode == 4 || mode == 6) begin
            m = $urandom_range(4, 1);
            if (m == 4) begin
                m = 5;
            end
        end
        u.pc = pc_t'($urandom) & 32'hffff_fffc;
        u.pred_taken = chance(50);
        u.tag = tag_t'($urandom);
        u.rs1 = $urandom;
        u.rs2 = $urandom;
        u.imm = $urandom;
        u.csr = $urandom;
        u.op1_sel = OP_RS1;
        u.op2_sel = OP_RS2;
        u.alu_op = alu_op_e'($urandom_range(9, 0));
        u.br_op = BR_NONE;
        u.csr_op = CSR_NONE;
        u.wb_sel = WB_ALU;
        case (m)
            1: begin
                if (chance(50)) begin
                    u.op2_sel = OP_IMM;
                end
            end
            2: begin
                u.op1_sel = opsel_e'($urandom_range(5, 0));
                u.op2_sel = opsel_e'($urandom_range(5, 0));
                u.wb_sel = wb_sel_e'($urandom_range(3, 0));
            end
            3: begin
                u.br_op = br_op_e'($urandom_range(6, 0));
                if (chance(25)) begin
                    u.rs2 = u.rs1;
                end
                u.wb_sel = WB_LINK;
            end
            5: begin
                u.csr_op = csr_op_e'($urandom_range(3, 0));
                u.op1_sel = OP_CSR;
                u.op2_sel = OP_RS1;
                u.alu_op = ALU_OR;
                u.wb_sel = WB_CSR;
            end
            default: begin
            end
        endcase
        return u;
    endfunction

    task automatic compare_word(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        check_count++;
        assert (exp === act) else begin
            err_count++;
            $display("Fail %s: %s expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // Drive one cycle just after the edge and check once the outputs have settled.
    task automatic step(input int mode, input int valid_pct, input int ready_pct,
                        input int flush_pct, output logic fired);
        exp_t e;
        logic exp_valid;
        logic exp_ready;
        logic fire;
        @(posedge clk_i);
        #1;
        // A presented micro-op is held until it fires or is flushed.
        if (valid_pct == 0 || !in_valid_i || last_fire || flush_i) begin
            in_valid_i = chance(valid_pct);
            cur = gen_uop(mode);
        end
        out_ready_i = chance(ready_pct);
        flush_i = chance(flush_pct);
        #2;
        exp_valid = (exp_q.size() != 0);
        exp_ready = !exp_valid || out_ready_i;
        compare_word("out_valid_o", exp_valid, out_valid_o);
        if (exp_valid) begin
            compare_word("out_tag_o", exp_q[0].tag, out_tag_o);
            compare_word("out_pc_o", exp_q[0].pc, out_pc_o);
            compare_word("out_rd_val_o", exp_q[0].rd, out_rd_val_o);
            compare_word("out_csr_val_o", exp_q[0].csr, out_csr_val_o);
            if (out_ready_i) begin
                exp_q.delete(0);
            end
        end
        compare_word("in_ready_o", exp_ready, in_ready_o);
        fire = in_valid_i && exp_ready && !flush_i;
        e = model_uop(cur);
        compare_word("redirect_valid_o", fire && e.mispredict, redirect_valid_o);
        compare_word("bp_update_o", fire && e.is_br, bp_update_o);
        compare_word("trap_valid_o", fire && e.trap, trap_valid_o);
        if (fire && e.mispredict) begin
            compare_word("redirect_pc_o", e.target, redirect_pc_o);
        end
        if (fire && e.is_br) begin
            compare_word("bp_pc_o", e.pc, bp_pc_o);
            compare_word("bp_taken_o", e.taken, bp_taken_o);
            compare_word("bp_mispredict_o", e.mispredict, bp_mispredict_o);
        end
        if (fire && e.trap) begin
            compare_word("trap_pc_o", e.pc, trap_pc_o);
            compare_word("trap_cause_o", EXC_MRET, trap_cause_o);
        end
        if (fire) begin
            exp_q.push_back(e);
        end
        if (flush_i) begin
            exp_q.delete();
        end
        last_fire = fire;
        fired = fire;
    endtask

    task automatic run_test(input string name, input int mode, input int n_uops,
                            input int valid_pct, input int ready_pct, input int flush_pct);
        int   fired_total;
        int   cycles;
        int   errs_at_start;
        logic fired;
        test_name = name;
        errs_at_start = err_count;
        fired_total = 0;
        cycles = 0;
        while (fired_total < n_uops && cycles < 40 * n_uops) begin
            step(mode, valid_pct, ready_pct, flush_pct, fired);
            fired_total += fired;
            cycles++;
        end
        if (fired_total < n_uops) begin
            timed_out = 1'b1;
            $display("Timeout in %s: only %0d of %0d micro-ops were accepted",
                     name, fired_total, n_uops);
        end
        // Drain the output so the next test starts from an empty stage.
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 50) begin
            step(0, 0, 100, 0, fired);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            timed_out = 1'b1;
            $display("Timeout in %s: the output register never drained", name);
        end
        if (err_count != errs_at_start || timed_out) begin
            tests_failed++;
        end
        $display("Test %-12s %4d micro-ops, %0d errors", name, fired_total,
                 err_count - errs_at_start);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int seed_val;
        seed_val = $urandom(SEED);
        rstn_i = 1'b0;
        flush_i = 1'b0;
        in_valid_i = 1'b0;
        out_ready_i = 1'b0;
        cur = '0;
        err_count = 0;
        check_count = 0;
        tests_failed = 0;
        timed_out = 1'b0;
        last_fire = 1'b0;
        test_name = "reset";
        repeat (3) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        if (!timed_out) run_test("alu", 1, 200, 80, 90, 2);
        if (!timed_out) run_test("select", 2, 200, 80, 90, 2);
        if (!timed_out) run_test("branch", 3, 300, 80, 90, 2);
        if (!timed_out) run_test("backpressure", 4, 200, 90, 30, 2);
        if (!timed_out) run_test("csr_trap", 5, 150, 80, 90, 2);
        if (!timed_out) run_test("flush", 6, 150, 80, 70, 25);

        $display("Summary: %0d tests failed, %0d checks, %0d errors",
                 tests_failed, check_count, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
